// ==== verilog/routerCfgPkg.sv ====
// router configuration shared by the output stage

package routerCfgPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mesh directions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NumDirs = 5; // fixed by the mesh

  typedef logic [2:0] dirIdx_t;

  typedef enum logic [2:0]
  {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    West  = 3'd3,
    South = 3'd4
  } dir_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizing defaults
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DefaultQueueDepth = 4; // flits per input queue

endpackage

// ==== verilog/nocFlitPkg.sv ====
// flit formats carried through the router

package nocFlitPkg;

  localparam int LengthBits = 12;

  // header, zero or more body flits, then tail
  typedef enum logic [1:0]
  {
    Header = 2'd0,
    Body   = 2'd1,
    Tail   = 2'd2
  } flitKind_t;

  typedef struct packed
  {
    logic [LengthBits-1:0] length;   // body flits before the tail
    logic [3:0]            msgClass;
  } headerWord_t;

  // header flits decode the word as headerWord_t, the rest as payload
  typedef union packed
  {
    headerWord_t header;
    logic [15:0] payload;
  } flitData_u;

  typedef struct packed
  {
    flitKind_t kind;
    flitData_u data;
  } flit_t;

  typedef struct packed
  {
    routerCfgPkg::dirIdx_t src; // direction the flit came from
    flit_t                 flit;
  } outFlit_t;

endpackage

// ==== verilog/inputQueue.sv ====
`timescale 1ns/10ps

module inputQueue
#(
  parameter int QueueDepth = routerCfgPkg::DefaultQueueDepth
)
(
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  output logic               inReady,
  input  nocFlitPkg::flit_t  inFlit,
  output logic               headValid,
  output nocFlitPkg::flit_t  headFlit,
  input  logic               pop
);
  import nocFlitPkg::*;

  localparam int PtrBits   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CountBits = $clog2(QueueDepth + 1);

  flit_t                store [QueueDepth];
  logic [PtrBits-1:0]   wrPtr;
  logic [PtrBits-1:0]   rdPtr;
  logic [CountBits-1:0] fillCount;
  logic [CountBits-1:0] nextCount;
  logic                 push;
  logic                 pull;

  function automatic logic [PtrBits-1:0] wrap(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(QueueDepth - 1)) ? '0 : ptr + PtrBits'(1);
  endfunction

  assign push      = inValid && inReady;
  assign pull      = pop && headValid;
  assign headValid = (fillCount != '0); // doubles as the arbiter request
  assign headFlit  = store[rdPtr];
  assign inReady   = !rst && (fillCount != CountBits'(QueueDepth)); // not full and out of reset

  always_comb
  begin
    nextCount = fillCount;
    if (push && !pull)
      nextCount = fillCount + CountBits'(1);
    else if (pull && !push)
      nextCount = fillCount - CountBits'(1);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and fill level
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrap(wrPtr);
      if (pull)
        rdPtr <= wrap(rdPtr);
      fillCount <= nextCount;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      store[wrPtr] <= inFlit;
  end

endmodule

// ==== verilog/packetTimer.sv ====
`timescale 1ns/10ps

module packetTimer
(
  input  logic              clk,
  input  logic              rst,
  input  nocFlitPkg::flit_t headFlit,
  input  logic              step,
  output logic              lastFlit
);
  import nocFlitPkg::*;

  logic [LengthBits-1:0] pktLength; // body length from the header
  logic [LengthBits-1:0] flitCount; // flits moved since the header

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLength <= '0;
      flitCount <= '0;
    end
    else if (step)
    begin
      if (headFlit.kind == Header)
      begin
        pktLength <= headFlit.data.header.length;
        flitCount <= '0;
      end
      else
        flitCount <= flitCount + LengthBits'(1);
    end
  end

  // count reaches length when the tail sits at the head
  assign lastFlit = (headFlit.kind != Header) && (flitCount == pktLength);

endmodule

// ==== verilog/portArbiter.sv ====
`timescale 1ns/10ps

module portArbiter
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [routerCfgPkg::NumDirs-1:0]    headValid,
  input  nocFlitPkg::flit_t                   headFlit [routerCfgPkg::NumDirs],
  input  logic                                advance,
  output logic [routerCfgPkg::NumDirs-1:0]    grant,
  output routerCfgPkg::dirIdx_t               grantIdx
);
  import routerCfgPkg::*;

  typedef enum logic
  {
    ArbIdle    = 1'b0,
    ArbGranted = 1'b1
  } arbState_e;

  arbState_e          state;
  dirIdx_t            rotPtr;   // first direction to search
  logic [NumDirs-1:0] lastFlit;
  logic [NumDirs-1:0] reqMask;
  logic [NumDirs-1:0] pickOneHot;
  dirIdx_t            pickIdx;
  logic               found;
  logic               tailDone;

  function automatic dirIdx_t stepDir(input dirIdx_t dir);
    return (dir == dirIdx_t'(South)) ? dirIdx_t'(Local) : dir + dirIdx_t'(1);
  endfunction

  for (genvar d = 0; d < NumDirs; d++)
  begin : timerGen
    packetTimer i_timer
    (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[d]),
      .step     (grant[d] & advance),
      .lastFlit (lastFlit[d])
    );
  end

  // the direction releasing its tail competes again only after going idle
  assign reqMask  = headValid & ~grant;
  assign tailDone = (state == ArbGranted) && advance && lastFlit[grantIdx];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // rotating scan
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    dirIdx_t probe;
    probe      = rotPtr;
    found      = 1'b0;
    pickIdx    = rotPtr;
    pickOneHot = '0;
    for (int i = 0; i < NumDirs; i++)
    begin
      if (!found && reqMask[probe])
      begin
        found             = 1'b1;
        pickIdx           = probe;
        pickOneHot[probe] = 1'b1;
      end
      probe = stepDir(probe);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ArbIdle;
      grant    <= '0;
      grantIdx <= dirIdx_t'(Local);
      rotPtr   <= dirIdx_t'(Local);
    end
    else if (state == ArbIdle || tailDone) // grant only moves at a packet boundary
    begin
      if (found)
      begin
        state    <= ArbGranted;
        grant    <= pickOneHot;
        grantIdx <= pickIdx;
        rotPtr   <= stepDir(pickIdx);
      end
      else
      begin
        state <= ArbIdle;
        grant <= '0;
      end
    end
  end

endmodule

// ==== verilog/outputRegister.sv ====
`timescale 1ns/10ps

module outputRegister
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic [routerCfgPkg::NumDirs-1:0] grant,
  input  routerCfgPkg::dirIdx_t            grantIdx,
  input  logic [routerCfgPkg::NumDirs-1:0] headValid,
  input  nocFlitPkg::flit_t                headFlit [routerCfgPkg::NumDirs],
  output logic                             advance,
  output logic                             outValid,
  input  logic                             outReady,
  output nocFlitPkg::outFlit_t             outFlit
);
  import nocFlitPkg::*;

  flit_t selFlit;
  logic  selValid;

  assign selFlit  = headFlit[grantIdx];
  assign selValid = |(grant & headValid);

  // load when empty or draining this cycle
  assign advance = selValid && (!outValid || outReady);

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (advance)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (advance)
    begin
      outFlit.src  <= grantIdx; // tag with source direction
      outFlit.flit <= selFlit;
    end
  end

endmodule

// ==== verilog/routerOutputStage.sv ====
`timescale 1ns/10ps

module routerOutputStage
#(
  parameter int QueueDepth = routerCfgPkg::DefaultQueueDepth
)
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic [routerCfgPkg::NumDirs-1:0] inValid,
  output logic [routerCfgPkg::NumDirs-1:0] inReady,
  input  nocFlitPkg::flit_t                inFlit [routerCfgPkg::NumDirs],
  output logic                             outValid,
  input  logic                             outReady,
  output nocFlitPkg::outFlit_t             outFlit
);
  import nocFlitPkg::*;
  import routerCfgPkg::*;

  logic [NumDirs-1:0] headValid;
  flit_t              headFlit [NumDirs];
  logic [NumDirs-1:0] grant;
  dirIdx_t            grantIdx;
  logic               advance;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar d = 0; d < NumDirs; d++)
  begin : queueGen
    inputQueue #(.QueueDepth(QueueDepth)) i_queue
    (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[d]),
      .inReady   (inReady[d]),
      .inFlit    (inFlit[d]),
      .headValid (headValid[d]),
      .headFlit  (headFlit[d]),
      .pop       (grant[d] & headValid[d] & advance)
    );
  end

  portArbiter i_arbiter
  (
    .clk       (clk),
    .rst       (rst),
    .headValid (headValid),
    .headFlit  (headFlit),
    .advance   (advance),
    .grant     (grant),
    .grantIdx  (grantIdx)
  );

  outputRegister i_outReg
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .grantIdx  (grantIdx),
    .headValid (headValid),
    .headFlit  (headFlit),
    .advance   (advance),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit)
  );

endmodule

// ==== testbench/tbPacketModel.svh ====
`ifndef TB_PACKET_MODEL_SVH
`define TB_PACKET_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random source and packet builder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [31:0] nextRand();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

// header, len body flits, then tail
task automatic buildPacket(input int len, output flit_t flits[$]);
  flit_t f;
  logic [31:0] r;
  flits = {};
  r = nextRand();
  f.kind = Header;
  f.data.header.length = LengthBits'(len);
  f.data.header.msgClass = r[3:0];
  flits.push_back(f);
  for (int i = 0; i <= len; i++)
  begin
    r = nextRand();
    f.kind = (i == len) ? Tail : Body;
    f.data.payload = r[15:0];
    flits.push_back(f);
  end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference ordering
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [NumDirs-1:0] pendingMask();
  logic [NumDirs-1:0] m;
  m = '0;
  for (int d = 0; d < NumDirs; d++)
    m[d] = (expQ[d].size() != 0);
  return m;
endfunction

// directions with flits still waiting in the input queues
function automatic logic [NumDirs-1:0] queuedMask(input logic regValid, input dirIdx_t regSrc);
  logic [NumDirs-1:0] m;
  int                 n;
  m = '0;
  for (int d = 0; d < NumDirs; d++)
  begin
    n = expQ[d].size();
    if (regValid && regSrc == dirIdx_t'(d))
      n--; // this one sits in the output register
    m[d] = (n > 0);
  end
  return m;
endfunction

// next direction after last that has a packet waiting
function automatic dirIdx_t nextDir(input dirIdx_t last, input logic [NumDirs-1:0] pending);
  dirIdx_t probe;
  probe = last;
  for (int i = 0; i < NumDirs; i++)
  begin
    probe = (probe == dirIdx_t'(NumDirs - 1)) ? '0 : probe + dirIdx_t'(1);
    if (pending[probe])
      return probe;
  end
  return last;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic failRun(input string why);
  $display("%s at %0t", why, $time);
  $display("RESULT: FAIL");
  $fatal(1);
endtask

task automatic checkFlit(input string name, input flit_t got, input flit_t exp);
  if (got !== exp)
  begin
    $display("** Error @ %0t: %s got %h expected %h", $time, name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1);
  end
endtask

task automatic checkSrc(input string name, input dirIdx_t got, input dirIdx_t exp);
  if (got !== exp)
  begin
    $display("** Error @ %0t: %s got %0d expected %0d", $time, name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1);
  end
endtask

`endif

// ==== testbench/routerOutputStageTb.sv ====
`timescale 1ns/10ps

module routerOutputStageTb;
  import nocFlitPkg::*;
  import routerCfgPkg::*;

  localparam int QueueDepth = 4;

  logic               clk;
  logic               rst;
  logic [NumDirs-1:0] inValid;
  logic [NumDirs-1:0] inReady;
  flit_t              inFlit [NumDirs];
  logic               outValid;
  logic               outReady;
  outFlit_t           outFlit;

  flit_t              expQ [NumDirs][$]; // per-direction expected flits
  int                 sentFlits;
  int                 cycles;
  int                 acceptCount [NumDirs];
  logic [31:0]        rngState;
  bit                 toggleReady;
  bit                 inPacket;
  bit                 holdCheck;
  bit                 waitPick;
  bit                 havePick;
  bit                 prevValid;
  bit                 prevReady;
  logic [NumDirs-1:0] prevQueued;
  dirIdx_t            pickSrc;
  dirIdx_t            lastSrc;
  dirIdx_t            curSrc;
  outFlit_t           heldFlit;

  `include "tbPacketModel.svh"

  routerOutputStage #(.QueueDepth(QueueDepth)) i_dut
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > 4 * sentFlits + 200)
      failRun("timeout, output stopped delivering flits");
  end

  // random sink readiness
  always @(posedge clk)
  begin : readyToggle
    logic [31:0] r;
    #2;
    if (toggleReady)
    begin
      r = nextRand();
      outReady = r[0];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk)
  begin : monitor
    outFlit_t           got;
    flit_t              exp;
    logic [NumDirs-1:0] queued;
    logic [NumDirs-1:0] others;
    if (rst)
    begin
      holdCheck  = 1'b0;
      waitPick   = 1'b1;
      havePick   = 1'b0;
      prevValid  = 1'b0;
      prevReady  = 1'b0;
      prevQueued = '0;
    end
    else
    begin
      if (holdCheck) // stalled flit must stay put
      begin
        if (!outValid)
          failRun("outValid dropped while outReady was low");
        checkFlit("outFlit.flit", outFlit.flit, heldFlit.flit);
        checkSrc("outFlit.src", outFlit.src, heldFlit.src);
      end
      holdCheck = outValid && !outReady;
      heldFlit  = outFlit;

      // rotation decisions see the queues as they were before the edge
      queued = queuedMask(outValid, outFlit.src);
      if (waitPick && prevQueued != '0) // idle link picks up a request
      begin
        pickSrc  = nextDir(lastSrc, prevQueued);
        havePick = 1'b1;
        waitPick = 1'b0;
      end
      if (outValid && (!prevValid || prevReady) && outFlit.flit.kind == Tail)
      begin
        others              = prevQueued;
        others[outFlit.src] = 1'b0;
        lastSrc             = outFlit.src;
        if (others != '0)
        begin
          pickSrc  = nextDir(lastSrc, others);
          havePick = 1'b1;
        end
        else
          waitPick = 1'b1;
      end
      prevValid  = outValid;
      prevReady  = outReady;
      prevQueued = queued;

      if (outValid && outReady)
      begin
        got = outFlit;
        if (got.src >= NumDirs || expQ[got.src].size() == 0)
          failRun("output flit from a direction with nothing pending");
        if (got.flit.kind == Header)
        begin
          if (inPacket)
            failRun("header arrived inside an open packet");
          if (!havePick)
            failRun("header sent while no direction was due");
          checkSrc("outFlit.src", got.src, pickSrc);
          havePick = 1'b0;
          inPacket = 1'b1;
          curSrc   = got.src;
        end
        else
        begin
          if (!inPacket)
            failRun("body or tail flit outside a packet");
          checkSrc("outFlit.src", got.src, curSrc); // no interleaving
        end
        exp = expQ[got.src].pop_front();
        checkFlit("outFlit.flit", got.flit, exp);
        if (got.flit.kind == Tail)
          inPacket = 1'b0;
      end
    end
  end

  task automatic applyReset();
    rst      = 1'b1;
    inPacket = 1'b0;
    lastSrc  = dirIdx_t'(South); // rotation restarts at Local
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
  endtask

  task automatic sendPacket(input int d, input flit_t flits[$]);
    bit acc;
    foreach (flits[i])
    begin
      inValid[d] = 1'b1;
      inFlit[d]  = flits[i];
      sentFlits++;
      acc = 1'b0;
      while (!acc)
      begin
        @(negedge clk);
        acc = inReady[d];
        @(posedge clk);
        #2;
      end
      expQ[d].push_back(flits[i]);
      acceptCount[d]++;
    end
    inValid[d] = 1'b0;
  endtask

  task automatic sendLen(input int d, input int len);
    flit_t flits[$];
    buildPacket(len, flits);
    sendPacket(d, flits);
  endtask

  task automatic drain();
    while (pendingMask() != '0 || inPacket)
      @(posedge clk);
    #2;
  endtask

  initial
  begin
    inValid     = '0;
    outReady    = 1'b0;
    rngState    = 32'd42915;
    sentFlits   = 0;
    cycles      = 0;
    toggleReady = 1'b0;
    holdCheck   = 1'b0;
    for (int d = 0; d < NumDirs; d++)
    begin
      inFlit[d]      = '0;
      acceptCount[d] = 0;
    end
    applyReset();

    // north only including a zero length packet
    outReady = 1'b1;
    sendLen(North, 0);
    sendLen(North, 3);
    sendLen(North, 1);
    sendLen(North, 5);
    drain();

    // round robin with everything loaded behind a stall
    applyReset();
    outReady = 1'b0;
    fork
      sendLen(Local, 1);
      sendLen(North, 1);
      sendLen(East, 1);
      sendLen(West, 1);
      sendLen(South, 1);
    join
    outReady = 1'b1;
    drain();
    outReady = 1'b0;
    fork
      sendLen(Local, 1);
      sendLen(West, 1);
    join
    outReady = 1'b1;
    drain();

    // random traffic with a random sink
    toggleReady = 1'b1;
    for (int i = 0; i < NumDirs; i++)
    begin
      fork
        automatic int d = i;
        begin : randomSource
          automatic logic [31:0] r;
          for (int p = 0; p < 4; p++)
          begin
            r = nextRand();
            repeat (r[1:0]) @(posedge clk);
            #2;
            sendLen(d, int'(r[7:4]) % 7);
          end
        end
      join_none
    end
    wait fork;
    drain();
    toggleReady = 1'b0;
    @(posedge clk);
    #2 outReady = 1'b0;

    // output register absorbs one flit beyond the queue
    acceptCount[East] = 0;
    fork
      sendLen(East, 4);
    join_none
    repeat (15) @(posedge clk);
    @(negedge clk);
    if (acceptCount[East] != QueueDepth + 1 || inReady[East])
      failRun("East inReady did not fall once its queue filled");
    @(posedge clk);
    #2 outReady = 1'b1;
    wait fork;
    drain();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+testbench
verilog/routerCfgPkg.sv
verilog/nocFlitPkg.sv
verilog/inputQueue.sv
verilog/packetTimer.sv
verilog/portArbiter.sv
verilog/outputRegister.sv
verilog/routerOutputStage.sv
testbench/routerOutputStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the router output stage testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module routerOutputStageTb -Mdir obj_dir &&
./obj_dir/VrouterOutputStageTb | tee /dev/stderr | grep -q "^RESULT: PASS$" ||
exit 1
